// ==== Makefile ====
TOP := pcw_glue_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== project.f ====
verilog/pcw_pkg.sv
verilog/pcw_io_regs.sv
verilog/pcw_page_map.sv
verilog/pcw_int_ctrl.sv
verilog/pcw_palette.sv
verilog/pcw_glue_core.sv
verif/pcw_glue_core_sva.sv
verif/pcw_glue_core_tb.sv

// ==== verif/pcw_glue_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_glue_core_sva
    import pcw_pkg::*;
(
    input logic              clk_sys,
    input logic              reset,
    input logic [MISS_W-1:0] timer_misses,
    input logic              clear_busy,        // Delayed clear running
    input logic              nmi,
    input logic              irq
);

    // Both lines come out of reset low
    reset_lines_low: assert property (@(posedge clk_sys) reset |=> (!nmi && !irq))
        else $error("nmi or irq high the cycle after reset");

    // Saturating count only drops to zero through the F4 clear
    misses_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
        (timer_misses == '0 && $past(timer_misses) == '1) |-> ($past(clear_busy) || $past(reset)))
        else $error("timer_misses went from 15 to 0 without a clear");

endmodule

bind pcw_int_ctrl pcw_glue_core_sva pcw_glue_core_sva_i (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .timer_misses (timer_misses),
    .clear_busy   (clear_busy),
    .nmi          (nmi),
    .irq          (irq)
);

`default_nettype wire

// ==== verif/pcw_glue_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_glue_core_tb
    import pcw_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // Rough cycle count per test
    localparam int RESET_CYC  = 20;
    localparam int PCW_CYC    = 4 * (4 * 2 + 50);
    localparam int CPC_CYC    = 2 * (5 * 2 + 50);
    localparam int TIMER_CYC  = 18 * 5 + 2 * 45 + 20;
    localparam int DISK_CYC   = 4 * 5 + 3 * 4 + 45 + 7 * 2 + 20;
    localparam int PAL_CYC    = 16 * (2 + 4);
    localparam int TOTAL_CYC  = RESET_CYC + PCW_CYC + CPC_CYC + TIMER_CYC + DISK_CYC + PAL_CYC;
    localparam int WATCHDOG_NS = 2 * TOTAL_CYC * CLK_PERIOD;  // Double as margin

    // Which DUT output the compare process samples
    localparam int SRC_DIN  = 0;
    localparam int SRC_ADDR = 1;
    localparam int SRC_RGB  = 2;
    localparam int SRC_NMI  = 3;
    localparam int SRC_IRQ  = 4;
    localparam int SRC_CTL  = 5;

    logic              clk_sys, reset;
    logic [ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0] cpu_dout, io_din;
    logic              io_wr, io_rd, mem_wr;
    mem_size_e         memory_size;
    logic [PHYS_W-1:0] mem_addr;
    logic              timer_tick, fdc_int, iff1, vblank, ntsc;
    logic              nmi, irq, disk_tc, motor, speaker_enable;
    logic [1:0]        pix_colour;
    logic [7:0]        ypos;
    disp_colour_e      disp_color;
    fake_mode_e        fake_colour_mode;
    logic [RGB_W-1:0]  rgb;

    // Register model
    logic [7:0]        model_pages [4];
    logic [7:0]        model_lock, model_fend;
    logic [MISS_W-1:0] model_misses;

    logic [31:0] rng = 32'ha756;
    string       cmp_name, cur_test;
    int          cmp_src;
    logic [31:0] cmp_exp;
    event        sample_ev;
    int          checks, errors, test_err_start, tests_run, tests_failed;

    // F8 opcodes and expected {disk_tc, motor, speaker_enable} after each
    sys_cmd_e   ctl_cmds [7] = '{CMD_END_BOOT, CMD_TC_SET, CMD_MOTOR_ON, CMD_SPK_ON,
                                 CMD_TC_CLR, CMD_MOTOR_OFF, CMD_SPK_OFF};
    logic [2:0] ctl_exp [7]  = '{3'b000, 3'b100, 3'b110, 3'b111, 3'b011, 3'b001, 3'b000};

    pcw_glue_core pcw_glue_core_i (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Page register picked by A15:14 and PCW or CPC mode by bit 7
    function automatic logic [PHYS_W-1:0] ref_mem_addr(input logic [ADDR_W-1:0] addr,
                                                       input logic wr, input int msize);
        logic [7:0] pg;
        logic [6:0] mask;
        logic [2:0] cpc;
        int         slot;
        slot = int'(addr[15:14]);
        pg   = model_pages[slot];
        mask = 7'h7f >> (3 - msize);             // 4 to 7 page bits
        if (pg[7]) begin
            return {pg[6:0] & mask, addr[13:0]};
        end
        cpc = (wr || model_lock[4 + slot]) ? pg[2:0] : pg[6:4];
        return {4'b0000, cpc, addr[13:0]};
    endfunction

    function automatic logic [RGB_W-1:0] ref_rgb(input logic [1:0] pix, input logic [7:0] y,
                                                 input int disp, input int mode);
        logic [RGB_W-1:0] cga [4];
        if (mode != 0 && y < model_fend) begin   // Inside the fake-colour band
            case (mode)
                1: cga = '{RGB_CGA_BLACK, RGB_CGA_DK_GREEN, RGB_CGA_DK_RED, RGB_CGA_BROWN};
                2: cga = '{RGB_CGA_BLACK, RGB_CGA_LT_GREEN, RGB_CGA_LT_RED, RGB_CGA_YELLOW};
                default: cga = '{RGB_CGA_BLACK, RGB_CGA_CYAN, RGB_CGA_MAGENTA, RGB_WHITE};
            endcase
            return cga[pix];
        end
        if (pix == 2'b00) return '0;
        case (disp)
            1:       return RGB_GREEN;
            2:       return RGB_AMBER;
            default: return RGB_WHITE;           // 0 and 3
        endcase
    endfunction

    function automatic logic [7:0] status_byte(input logic fdc);
        return {1'b0, vblank, fdc, ~ntsc, model_misses};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, name, exp, act);
        end
    endtask

    // Compare process samples the chosen output
    initial begin
        forever begin
            @(sample_ev);
            case (cmp_src)
                SRC_DIN:  check_value(cmp_name, cmp_exp, 32'(io_din));
                SRC_ADDR: check_value(cmp_name, cmp_exp, 32'(mem_addr));
                SRC_RGB:  check_value(cmp_name, cmp_exp, 32'(rgb));
                SRC_NMI:  check_value(cmp_name, cmp_exp, 32'(nmi));
                SRC_IRQ:  check_value(cmp_name, cmp_exp, 32'(irq));
                default:  check_value(cmp_name, cmp_exp, 32'({disk_tc, motor, speaker_enable}));
            endcase
        end
    end

    task automatic expect_now(input string name, input int src, input logic [31:0] exp);
        cmp_name = name;
        cmp_src  = src;
        cmp_exp  = exp;
        -> sample_ev;
        #1;
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        @(posedge clk_sys);
        #1;
        cpu_addr = {8'h00, port};
        cpu_dout = data;
        io_wr    = 1'b1;
        @(posedge clk_sys);
        #1;
        io_wr = 1'b0;
    endtask

    task automatic read_port(input string name, input logic [7:0] port, input logic [7:0] exp);
        @(posedge clk_sys);
        #1;
        cpu_addr = {8'h00, port};
        io_rd    = 1'b1;
        #2;
        expect_now(name, SRC_DIN, 32'(exp));     // io_din valid in the strobe cycle
        @(posedge clk_sys);
        #1;
        io_rd = 1'b0;
    endtask

    task automatic write_page(input int idx, input logic [7:0] val);
        io_write(8'(PORT_PAGE0 + idx), val);
        model_pages[idx] = val;
    endtask

    task automatic apply_addr(input string name, input logic [15:0] addr, input logic wr,
                              input int msize);
        @(posedge clk_sys);
        #1;
        cpu_addr = addr;
        mem_wr   = wr;
        #2;
        expect_now(name, SRC_ADDR, 32'(ref_mem_addr(addr, wr, msize)));
    endtask

    task automatic sys_cmd(input sys_cmd_e cmd);
        io_write(PORT_SYSCTL, {4'h0, cmd});
    endtask

    // Tick held two edges so the edge detector sees it
    task automatic timer_pulse();
        @(posedge clk_sys);
        #1;
        timer_tick = 1'b1;
        repeat (2) @(posedge clk_sys);
        #1;
        timer_tick = 1'b0;
        repeat (2) @(posedge clk_sys);
        #1;
        if (model_misses != 4'hf) model_misses = model_misses + 4'h1;
    endtask

    task automatic set_fdc(input logic level);
        @(posedge clk_sys);
        #1;
        fdc_int = level;
        repeat (3) @(posedge clk_sys);
        #1;
    endtask

    task automatic set_iff1(input logic level);
        @(posedge clk_sys);
        #1;
        iff1 = level;
    endtask

    // F4 read acknowledges the timer and the clear lands 33 cycles on
    task automatic clear_timer(input logic fdc);
        read_port("timer_ack", PORT_CPC_LOCK, status_byte(fdc));
        repeat (40) @(posedge clk_sys);
        #1;
        model_misses = '0;
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset            = 1'b1;
        cpu_addr         = '0;
        cpu_dout         = '0;
        io_wr            = 1'b0;
        io_rd            = 1'b0;
        mem_wr           = 1'b0;
        memory_size      = MEM_2M;
        timer_tick       = 1'b0;
        fdc_int          = 1'b0;
        iff1             = 1'b0;
        vblank           = 1'b1;
        ntsc             = 1'b0;                 // Status shows 50 Hz bit set
        pix_colour       = 2'b00;
        ypos             = '0;
        disp_color       = DISP_WHITE;
        fake_colour_mode = FAKE_OFF;
        model_pages      = '{PAGE_RESET_0, PAGE_RESET_1, PAGE_RESET_2, PAGE_RESET_3};
        model_lock       = CPC_LOCK_RESET;
        model_fend       = '0;
        model_misses     = '0;
        repeat (2) @(posedge clk_sys);
        #1;
        reset = 1'b0;

        begin_test("reset_values");
        read_port("reset_f8", PORT_SYSCTL, status_byte(1'b0));
        read_port("reset_f4", PORT_CPC_LOCK, status_byte(1'b0));
        expect_now("reset_nmi", SRC_NMI, 32'd0);
        expect_now("reset_irq", SRC_IRQ, 32'd0);
        expect_now("reset_ctl", SRC_CTL, 32'd0);
        apply_addr("reset_page0", 16'h0000, 1'b0, 3);
        end_test();

        begin_test("pcw_paging");
        for (int s = 0; s < 4; s++) begin
            for (int p = 0; p < 4; p++) begin
                rng = xorshift32(rng);
                write_page(p, rng[7:0] | 8'h80);  // Extended mode
            end
            memory_size = mem_size_e'(s);
            for (int n = 0; n < 50; n++) begin
                rng = xorshift32(rng);
                apply_addr("pcw_paging", rng[15:0], rng[16], s);
            end
        end
        end_test();

        begin_test("cpc_paging");
        for (int r = 0; r < 2; r++) begin
            for (int p = 0; p < 4; p++) begin
                rng = xorshift32(rng);
                write_page(p, rng[7:0] & 8'h7f);
            end
            rng = xorshift32(rng);
            io_write(PORT_CPC_LOCK, rng[7:0]);
            model_lock = rng[7:0];
            for (int n = 0; n < 50; n++) begin
                rng = xorshift32(rng);
                apply_addr("cpc_paging", rng[15:0], rng[20], 3);  // Read and write maps
            end
        end
        @(posedge clk_sys);
        #1;
        mem_wr = 1'b0;
        end_test();

        begin_test("timer");
        repeat (16) timer_pulse();
        read_port("timer_saturate", PORT_SYSCTL, status_byte(1'b0));
        clear_timer(1'b0);
        read_port("timer_cleared", PORT_SYSCTL, status_byte(1'b0));
        set_iff1(1'b1);
        timer_pulse();
        expect_now("timer_irq", SRC_IRQ, 32'd1);
        clear_timer(1'b0);
        expect_now("timer_irq_cleared", SRC_IRQ, 32'd0);
        end_test();

        begin_test("disk_int");
        sys_cmd(CMD_DISK_NMI);
        set_fdc(1'b1);
        timer_pulse();
        expect_now("disk_nmi", SRC_NMI, 32'd1);
        expect_now("disk_nmi_masks_irq", SRC_IRQ, 32'd0);
        read_port("disk_status", PORT_SYSCTL, status_byte(1'b1));
        set_iff1(1'b0);
        sys_cmd(CMD_DISK_OFF);
        timer_pulse();
        expect_now("disk_off_nmi", SRC_NMI, 32'd0);
        expect_now("disk_off_irq", SRC_IRQ, 32'd0);
        set_fdc(1'b0);
        sys_cmd(CMD_DISK_INT);
        set_iff1(1'b1);
        set_fdc(1'b1);
        timer_pulse();
        expect_now("disk_irq", SRC_IRQ, 32'd1);
        expect_now("disk_irq_nmi", SRC_NMI, 32'd0);
        clear_timer(1'b1);                       // Timer line gone but FDC INT stays
        expect_now("disk_irq_held", SRC_IRQ, 32'd1);
        set_fdc(1'b0);
        sys_cmd(CMD_DISK_OFF);
        for (int i = 0; i < 7; i++) begin
            sys_cmd(ctl_cmds[i]);
            expect_now("disk_ctl", SRC_CTL, 32'(ctl_exp[i]));
        end
        end_test();

        begin_test("palette");
        for (int d = 0; d < 4; d++) begin
            for (int m = 0; m < 4; m++) begin
                rng = xorshift32(rng);
                io_write(PORT_FAKE_END, rng[7:0]);
                model_fend       = rng[7:0];
                disp_color       = disp_colour_e'(d);
                fake_colour_mode = fake_mode_e'(m);
                for (int p = 0; p < 4; p++) begin
                    rng = xorshift32(rng);
                    @(posedge clk_sys);
                    #1;
                    pix_colour = 2'(p);
                    ypos       = rng[7:0];
                    #2;
                    expect_now("palette", SRC_RGB, 32'(ref_rgb(2'(p), rng[7:0], d, m)));
                end
            end
        end
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/pcw_glue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_glue_core
    import pcw_pkg::*;
(
    input  logic              clk_sys,
    input  logic              reset,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_dout,
    input  logic              io_wr,
    input  logic              io_rd,
    input  logic              mem_wr,
    output logic [DATA_W-1:0] io_din,
    input  mem_size_e         memory_size,
    output logic [PHYS_W-1:0] mem_addr,
    input  logic              timer_tick,
    input  logic              fdc_int,
    input  logic              iff1,
    input  logic              vblank,
    input  logic              ntsc,
    output logic              nmi,
    output logic              irq,
    output logic              disk_tc,
    output logic              motor,
    output logic              speaker_enable,
    input  logic [1:0]        pix_colour,
    input  logic [7:0]        ypos,
    input  disp_colour_e      disp_color,
    input  fake_mode_e        fake_colour_mode,
    output logic [RGB_W-1:0]  rgb
);

    logic [DATA_W-1:0] page0, page1, page2, page3;
    logic [DATA_W-1:0] cpc_lock;
    logic [DATA_W-1:0] fake_end;
    logic              disk_to_nmi, disk_to_int;
    logic              int_mode_change;
    logic              clear_timer_start;       // F4 read seen
    logic [MISS_W-1:0] timer_misses;
    logic              fdc_status;

    pcw_io_regs pcw_io_regs_i (.*);             // Port bank and F8 commands

    pcw_page_map pcw_page_map_i (.*);

    pcw_int_ctrl pcw_int_ctrl_i (.*);           // Timer, FDC latch, NMI/INT

    pcw_palette pcw_palette_i (.*);

endmodule

`default_nettype wire

// ==== verilog/pcw_int_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_int_ctrl
    import pcw_pkg::*;
(
    input  logic              clk_sys,
    input  logic              reset,
    input  logic              timer_tick,        // 300 Hz from video side
    input  logic              fdc_int,
    input  logic              iff1,              // CPU interrupts enabled
    input  logic              disk_to_nmi,
    input  logic              disk_to_int,
    input  logic              int_mode_change,
    input  logic              clear_timer_start,
    output logic [MISS_W-1:0] timer_misses,
    output logic              fdc_status,
    output logic              nmi,
    output logic              irq
);

    // Bit 1 fdc_int, bit 0 timer_tick
    logic [1:0] in_q;                            // Sampled inputs
    logic [1:0] in_d;                            // One cycle older
    logic [1:0] rise;
    logic       fall;                            // fdc_int only

    logic               nmi_flag;                // FDC asked for NMI
    logic               nmi_line;
    logic               int_line;                // FDC interrupt on INT
    logic               timer_line;              // Timer interrupt on INT
    logic               clear_busy;
    logic [CLEAR_W-1:0] clear_count;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            in_q <= '0;
            in_d <= '0;
        end else begin
            in_q <= {fdc_int, timer_tick};
            in_d <= in_q;
        end
    end

    assign rise = in_q & ~in_d;
    assign fall = ~in_q[1] & in_d[1];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            timer_misses <= '0;
            fdc_status   <= 1'b0;
            nmi_flag     <= 1'b0;
            nmi_line     <= 1'b0;
            int_line     <= 1'b0;
            timer_line   <= 1'b0;
            clear_busy   <= 1'b0;
            clear_count  <= '0;
        end else begin
            // FDC status latch follows the interrupt edges
            if (rise[1]) begin
                fdc_status <= 1'b1;
                if (disk_to_nmi) nmi_flag <= 1'b1;
            end else if (fall) begin
                fdc_status <= 1'b0;
            end

            // Lines only change on a timer tick
            if (rise[0]) begin
                if (timer_misses != '1) timer_misses <= timer_misses + 1'b1;  // Saturate
                timer_line <= iff1;
                nmi_line   <= nmi_flag;
                int_line   <= disk_to_int & fdc_status & iff1;
            end

            // F4 read restarts the clear delay
            if (clear_timer_start) begin
                clear_busy  <= 1'b1;
                clear_count <= '0;
            end else if (clear_busy) begin
                if (clear_count == CLEAR_W'(CLEAR_CYCLES - 1)) begin
                    clear_busy   <= 1'b0;
                    timer_misses <= '0;          // Wins over a tick this cycle
                    timer_line   <= 1'b0;
                end else begin
                    clear_count <= clear_count + 1'b1;
                end
            end

            // Mode already updated when the pulse arrives
            if (int_mode_change) begin
                if (disk_to_nmi) begin
                    int_line <= 1'b0;
                end else if (disk_to_int) begin
                    nmi_flag <= 1'b0;
                end else begin
                    int_line <= 1'b0;            // Disconnected, drop both
                    nmi_flag <= 1'b0;
                end
            end
        end
    end

    assign nmi = nmi_line;
    assign irq = (int_line | timer_line) & ~nmi_line;  // Held off while NMI pending

endmodule

`default_nettype wire

// ==== verilog/pcw_io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_io_regs
    import pcw_pkg::*;
(
    input  logic              clk_sys,
    input  logic              reset,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic [DATA_W-1:0] cpu_dout,
    input  logic              io_wr,
    input  logic              io_rd,
    input  logic [MISS_W-1:0] timer_misses,
    input  logic              fdc_status,
    input  logic              vblank,
    input  logic              ntsc,
    output logic [DATA_W-1:0] io_din,
    output logic [DATA_W-1:0] page0,
    output logic [DATA_W-1:0] page1,
    output logic [DATA_W-1:0] page2,
    output logic [DATA_W-1:0] page3,
    output logic [DATA_W-1:0] cpc_lock,
    output logic              disk_to_nmi,       // FDC interrupt routed to NMI
    output logic              disk_to_int,       // FDC interrupt routed to INT
    output logic              int_mode_change,   // One cycle, after DISK_INT or DISK_OFF
    output logic              disk_tc,
    output logic              motor,
    output logic              speaker_enable,
    output logic [DATA_W-1:0] fake_end,
    output logic              clear_timer_start
);

    logic [7:0]        port_lo;                  // Only the low byte decodes
    logic [DATA_W-1:0] status;
    sys_cmd_e          cmd;

    assign port_lo = cpu_addr[7:0];
    assign cmd     = sys_cmd_e'(cpu_dout[3:0]);  // High nibble ignored

    // Flyback, FDC latch, 50/60 Hz and missed ticks
    assign status = {1'b0, vblank, fdc_status, ~ntsc, timer_misses};

    always_ff @(posedge clk_sys) begin
        int_mode_change <= 1'b0;                 // Pulse only
        if (reset) begin
            page0          <= PAGE_RESET_0;
            page1          <= PAGE_RESET_1;
            page2          <= PAGE_RESET_2;
            page3          <= PAGE_RESET_3;
            cpc_lock       <= CPC_LOCK_RESET;
            fake_end       <= '0;                // No fake band
            disk_to_nmi    <= 1'b0;
            disk_to_int    <= 1'b0;
            disk_tc        <= 1'b0;
            motor          <= 1'b0;
            speaker_enable <= 1'b0;
        end else if (io_wr) begin
            case (port_lo)
                PORT_PAGE0:    page0    <= cpu_dout;
                PORT_PAGE1:    page1    <= cpu_dout;
                PORT_PAGE2:    page2    <= cpu_dout;
                PORT_PAGE3:    page3    <= cpu_dout;
                PORT_CPC_LOCK: cpc_lock <= cpu_dout;
                PORT_FAKE_END: fake_end <= cpu_dout;
                PORT_SYSCTL: begin
                    // System control command
                    case (cmd)
                        CMD_DISK_NMI: begin
                            disk_to_nmi <= 1'b1;
                            disk_to_int <= 1'b0;  // No mode-change clear here
                        end
                        CMD_DISK_INT: begin
                            disk_to_nmi     <= 1'b0;
                            disk_to_int     <= 1'b1;
                            int_mode_change <= 1'b1;
                        end
                        CMD_DISK_OFF: begin      // Disconnect both
                            disk_to_nmi     <= 1'b0;
                            disk_to_int     <= 1'b0;
                            int_mode_change <= 1'b1;
                        end
                        CMD_TC_SET:    disk_tc        <= 1'b1;
                        CMD_TC_CLR:    disk_tc        <= 1'b0;
                        CMD_MOTOR_ON:  motor          <= 1'b1;
                        CMD_MOTOR_OFF: motor          <= 1'b0;
                        CMD_SPK_ON:    speaker_enable <= 1'b1;
                        CMD_SPK_OFF:   speaker_enable <= 1'b0;
                        default: ;               // END_BOOT and unused codes
                    endcase
                end
                default: ;
            endcase
        end
    end

    // Read mux, F4 returns status as well
    always_comb begin
        case (port_lo)
            PORT_CPC_LOCK,
            PORT_SYSCTL: io_din = status;
            default:     io_din = '1;            // Unmapped ports float high
        endcase
    end

    // Status read through F4 acknowledges the timer
    assign clear_timer_start = io_rd && (port_lo == PORT_CPC_LOCK);

endmodule

`default_nettype wire

// ==== verilog/pcw_page_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_page_map
    import pcw_pkg::*;
(
    input  logic [ADDR_W-1:0] cpu_addr,
    input  logic              mem_wr,            // Selects CPC write map
    input  mem_size_e         memory_size,
    input  logic [DATA_W-1:0] page0,
    input  logic [DATA_W-1:0] page1,
    input  logic [DATA_W-1:0] page2,
    input  logic [DATA_W-1:0] page3,
    input  logic [DATA_W-1:0] cpc_lock,
    output logic [PHYS_W-1:0] mem_addr
);

    logic [1:0]            slot;                 // Which 16K quarter
    logic [OFFSET_W-1:0]   offset;
    logic [DATA_W-1:0]     page;
    logic [PAGE_SEL_W-1:0] pcw_page;
    logic [2:0]            cpc_page;
    logic                  lock_bit;

    assign slot   = cpu_addr[ADDR_W-1 -: 2];
    assign offset = cpu_addr[OFFSET_W-1:0];

    always_comb begin
        case (slot)
            2'd0:    page = page0;
            2'd1:    page = page1;
            2'd2:    page = page2;
            default: page = page3;
        endcase
    end

    // Extended mode page number, masked to fitted memory
    always_comb begin
        case (memory_size)
            MEM_256K: pcw_page = {3'b000, page[3:0]};
            MEM_512K: pcw_page = {2'b00, page[4:0]};
            MEM_1M:   pcw_page = {1'b0, page[5:0]};
            default:  pcw_page = page[PAGE_SEL_W-1:0];
        endcase
    end

    // CPC mode
    // Lock bits 7:4 map slots 3:0
    assign lock_bit = cpc_lock[{1'b1, slot}];
    assign cpc_page = (mem_wr || lock_bit) ? page[2:0] : page[6:4];

    always_comb begin
        if (page[7]) begin
            mem_addr = {pcw_page, offset};
        end else begin
            mem_addr = {{(PHYS_W - OFFSET_W - 3){1'b0}}, cpc_page, offset};  // Bottom 128K
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pcw_palette.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcw_palette
    import pcw_pkg::*;
(
    input  logic [1:0]        pix_colour,
    input  logic [7:0]        ypos,              // Current display line
    input  disp_colour_e      disp_color,
    input  fake_mode_e        fake_colour_mode,
    input  logic [DATA_W-1:0] fake_end,
    output logic [RGB_W-1:0]  rgb
);

    logic [RGB_W-1:0] tint;
    logic [RGB_W-1:0] mono;
    logic [RGB_W-1:0] cga;
    logic             in_band;

    // Monitor phosphor
    always_comb begin
        case (disp_color)
            DISP_GREEN: tint = RGB_GREEN;
            DISP_AMBER: tint = RGB_AMBER;
            default:    tint = RGB_WHITE;        // Also code 3
        endcase
    end

    // PCW is 1 bpp, any set colour lights the pixel
    assign mono = (pix_colour == 2'b00) ? RGB_CGA_BLACK : tint;

    always_comb begin
        case (fake_colour_mode)
            FAKE_CGA0_LOW: begin
                case (pix_colour)
                    2'd0:    cga = RGB_CGA_BLACK;
                    2'd1:    cga = RGB_CGA_DK_GREEN;
                    2'd2:    cga = RGB_CGA_DK_RED;
                    default: cga = RGB_CGA_BROWN;
                endcase
            end
            FAKE_CGA0_HIGH: begin
                case (pix_colour)
                    2'd0:    cga = RGB_CGA_BLACK;
                    2'd1:    cga = RGB_CGA_LT_GREEN;
                    2'd2:    cga = RGB_CGA_LT_RED;
                    default: cga = RGB_CGA_YELLOW;
                endcase
            end
            default: begin                       // CGA1 high, OFF never selected
                case (pix_colour)
                    2'd0:    cga = RGB_CGA_BLACK;
                    2'd1:    cga = RGB_CGA_CYAN;
                    2'd2:    cga = RGB_CGA_MAGENTA;
                    default: cga = RGB_WHITE;
                endcase
            end
        endcase
    end

    // Colour band covers lines above fake_end
    assign in_band = (fake_colour_mode != FAKE_OFF) && (ypos < fake_end);

    assign rgb = in_band ? cga : mono;

endmodule

`default_nettype wire

// ==== verilog/pcw_pkg.sv ====
`default_nettype none

package pcw_pkg;

    // Bus and memory widths
    localparam int ADDR_W     = 16;             // Z80 address bus
    localparam int PHYS_W     = 21;             // 2 MB physical space
    localparam int DATA_W     = 8;
    localparam int PAGE_SEL_W = 7;              // Up to 128 pages of 16K
    localparam int OFFSET_W   = 14;             // Offset inside a 16K page
    localparam int RGB_W      = 18;             // 6-6-6 colour
    localparam int MISS_W     = 4;              // Missed 300 Hz ticks

    // Delayed timer clear after F4 read
    localparam int CLEAR_CYCLES = 32;
    localparam int CLEAR_W      = $clog2(CLEAR_CYCLES);

    // Low byte of the I/O port address
    localparam logic [7:0] PORT_PAGE0    = 8'hf0;  // 0000-3FFF
    localparam logic [7:0] PORT_PAGE1    = 8'hf1;  // 4000-7FFF
    localparam logic [7:0] PORT_PAGE2    = 8'hf2;  // 8000-BFFF
    localparam logic [7:0] PORT_PAGE3    = 8'hf3;  // C000-FFFF
    localparam logic [7:0] PORT_CPC_LOCK = 8'hf4;  // CPC read lock, read clears timer
    localparam logic [7:0] PORT_SYSCTL   = 8'hf8;  // Command write, status read
    localparam logic [7:0] PORT_FAKE_END = 8'hff;  // Last fake-colour line

    // Power-up register contents
    localparam logic [7:0] PAGE_RESET_0   = 8'h80;
    localparam logic [7:0] PAGE_RESET_1   = 8'h81;
    localparam logic [7:0] PAGE_RESET_2   = 8'h82;
    localparam logic [7:0] PAGE_RESET_3   = 8'h83;
    localparam logic [7:0] CPC_LOCK_RESET = 8'hf1;

    // Installed memory, sets the page bits kept (4 to 7)
    typedef enum logic [1:0] {MEM_256K, MEM_512K, MEM_1M, MEM_2M} mem_size_e;

    // System control opcodes, low nibble of an F8 write
    typedef enum logic [3:0] {
        CMD_END_BOOT  = 4'd0,
        CMD_DISK_NMI  = 4'd2,
        CMD_DISK_INT  = 4'd3,
        CMD_DISK_OFF  = 4'd4,
        CMD_TC_SET    = 4'd5,
        CMD_TC_CLR    = 4'd6,
        CMD_MOTOR_ON  = 4'd9,
        CMD_MOTOR_OFF = 4'd10,
        CMD_SPK_ON    = 4'd11,
        CMD_SPK_OFF   = 4'd12
    } sys_cmd_e;

    typedef enum logic [1:0] {DISP_WHITE, DISP_GREEN, DISP_AMBER} disp_colour_e;  // 3 is white too

    typedef enum logic [1:0] {FAKE_OFF, FAKE_CGA0_LOW, FAKE_CGA0_HIGH, FAKE_CGA1_HIGH} fake_mode_e;

    // Monochrome tints, R-G-B fields
    localparam logic [RGB_W-1:0] RGB_WHITE = {6'h3f, 6'h3f, 6'h37};
    localparam logic [RGB_W-1:0] RGB_GREEN = {6'h19, 6'h3f, 6'h19};
    localparam logic [RGB_W-1:0] RGB_AMBER = {6'h3f, 6'h2c, 6'h00};

    // CGA palettes
    localparam logic [RGB_W-1:0] RGB_CGA_BLACK    = {6'h00, 6'h00, 6'h00};
    localparam logic [RGB_W-1:0] RGB_CGA_DK_GREEN = {6'h00, 6'h2b, 6'h00};
    localparam logic [RGB_W-1:0] RGB_CGA_DK_RED   = {6'h2b, 6'h00, 6'h00};
    localparam logic [RGB_W-1:0] RGB_CGA_BROWN    = {6'h2b, 6'h16, 6'h00};
    localparam logic [RGB_W-1:0] RGB_CGA_LT_GREEN = {6'h16, 6'h3f, 6'h16};
    localparam logic [RGB_W-1:0] RGB_CGA_LT_RED   = {6'h3f, 6'h16, 6'h16};
    localparam logic [RGB_W-1:0] RGB_CGA_YELLOW   = {6'h3f, 6'h3f, 6'h16};
    localparam logic [RGB_W-1:0] RGB_CGA_CYAN     = {6'h16, 6'h3f, 6'h3f};
    localparam logic [RGB_W-1:0] RGB_CGA_MAGENTA  = {6'h3f, 6'h16, 6'h3f};

endpackage

`default_nettype wire
